/* hw/ant_params.svh */
`ifndef ANT_PARAMS_SVH
`define ANT_PARAMS_SVH

// Screen coordinate and pixel widths
`define X_COORD_WIDTH 8
`define Y_COORD_WIDTH 7
`define COLOUR_WIDTH 3

// Ant record contents
`define FITNESS_WIDTH 8

// Datapath word widths
`define MEM_ADDR_WIDTH 8
`define RESULT_WIDTH 16
`define OPCODE_WIDTH 4
`define INSTRUCTION_WIDTH 28

// Sprite size in pixels
`define ANT_WIDTH 4
`define ANT_HEIGHT 4

// Datapath opcodes, carried in the low bits of every instruction
`define OPCODE_MEMREAD `OPCODE_WIDTH'd1
`define OPCODE_MEMWRITE `OPCODE_WIDTH'd2
`define OPCODE_DRAW `OPCODE_WIDTH'd3

// Red in a 3-bit RGB frame buffer
`define COLOUR_ANT `COLOUR_WIDTH'd4

// Record layout
// A field sits at id * ANT_REC_WORDS + offset
`define ANT_REC_WORDS 4
`define ANT_FIELD_X 0
`define ANT_FIELD_Y 1
`define ANT_FIELD_FITNESS 2

`endif

/* hw/ant_pkg.sv */
`include "ant_params.svh"

package ant_pkg;

    // Host command kinds
    typedef enum logic {
        op_draw   = 1'b0,
        op_update = 1'b1
    } ant_op_e;

    // Move step from the host, one flag per direction
    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } ant_move_t;

    typedef struct packed {
        ant_op_e                    op;
        logic [`MEM_ADDR_WIDTH-1:0] id;
        ant_move_t                  move;
    } ant_cmd_t;

    // One entry per datapath operation, st_done doubles as idle
    typedef enum logic [2:0] {
        st_read_x        = 3'd0,
        st_read_y        = 3'd1,
        st_read_fitness  = 3'd2,
        st_draw_pixel    = 3'd3,
        st_write_x       = 3'd4,
        st_write_y       = 3'd5,
        st_write_fitness = 3'd6,
        st_done          = 3'd7
    } ant_step_e;

    // Record memory access layout
    typedef struct packed {
        logic [`RESULT_WIDTH-1:0]   data;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
        logic [`OPCODE_WIDTH-1:0]   opcode;
    } mem_instr_t;

    // Frame buffer pixel layout
    typedef struct packed {
        logic [4:0]                pad;
        logic                      plot;
        logic [`COLOUR_WIDTH-1:0]  colour;
        logic [`Y_COORD_WIDTH-1:0] y;
        logic [`X_COORD_WIDTH-1:0] x;
        logic [`OPCODE_WIDTH-1:0]  opcode;
    } draw_instr_t;

    // Opcode lands in the same bits in both layouts
    typedef union packed {
        mem_instr_t  mem;
        draw_instr_t draw;
    } ant_instr_u;

    typedef struct packed {
        logic [`X_COORD_WIDTH-1:0] x;
        logic [`Y_COORD_WIDTH-1:0] y;
        logic [`FITNESS_WIDTH-1:0] fitness;
    } ant_regs_t;

endpackage

/* hw/ant_cmd_decode.sv */
`include "ant_params.svh"

module ant_cmd_decode (
    input  logic              clock,
    input  logic              resetn,
    input  logic              start,
    input  ant_pkg::ant_cmd_t cmd,
    input  logic              step_done,
    output logic              finished,
    output ant_pkg::ant_step_e step,
    output ant_pkg::ant_cmd_t job
);
    import ant_pkg::*;

    ant_step_e next_step;

    // Step list for each op
    always_comb begin
        case (step)
            st_read_x: begin
                next_step = st_read_y;
            end
            st_read_y: begin
                if (job.op == op_draw) begin
                    next_step = st_draw_pixel;
                end else begin
                    next_step = st_read_fitness;
                end
            end
            st_read_fitness: begin
                next_step = st_write_x;
            end
            st_write_x: begin
                next_step = st_write_y;
            end
            st_write_y: begin
                next_step = st_write_fitness;
            end
            default: begin
                // Draw pixel and write fitness both end the command
                next_step = st_done;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            finished <= 1'b1;
            step <= st_done;
        end else if (finished) begin
            if (start) begin
                finished <= 1'b0;
                step <= st_read_x;
            end
        end else if (step_done) begin
            step <= next_step;
            if (next_step == st_done) begin
                finished <= 1'b1;
            end
        end
    end

    // Command is held for the whole run
    always_ff @(posedge clock) begin
        if (finished && start) begin
            job <= cmd;
        end
    end

    // Host may only start a command while the engine is idle
    a_start_when_idle: assert property (
        @(posedge clock) disable iff (!resetn)
        start |-> finished
    ) else $error("start pulsed while a command is still running");

endmodule

/* hw/ant_dp_sequencer.sv */
`include "ant_params.svh"

module ant_dp_sequencer (
    input  logic               clock,
    input  logic               resetn,
    input  ant_pkg::ant_step_e step,
    input  ant_pkg::ant_cmd_t  job,
    input  ant_pkg::ant_regs_t regs,
    input  logic               dp_finished,
    output logic               dp_start,
    output ant_pkg::ant_instr_u dp_instruction,
    output logic               step_done
);
    import ant_pkg::*;

    // Handshake phases
    localparam logic [1:0] ph_idle  = 2'd0;
    localparam logic [1:0] ph_start = 2'd1;
    localparam logic [1:0] ph_hold  = 2'd2;
    localparam logic [1:0] ph_wait  = 2'd3;

    logic [1:0]                phase;
    logic [`X_COORD_WIDTH-1:0] dx;
    logic [`Y_COORD_WIDTH-1:0] dy;
    logic                      last_pixel;
    logic                      issue;
    ant_instr_u                instr_next;

    function automatic logic [`MEM_ADDR_WIDTH-1:0] field_addr(
        input logic [`MEM_ADDR_WIDTH-1:0] id,
        input int                         offset
    );
        return `MEM_ADDR_WIDTH'(id * `ANT_REC_WORDS + offset);
    endfunction

    assign last_pixel = (dx == `X_COORD_WIDTH'(`ANT_WIDTH - 1)) &&
                        (dy == `Y_COORD_WIDTH'(`ANT_HEIGHT - 1));

    // A pending step is picked up from idle
    assign issue = (phase == ph_idle) && (step != st_done);

    // Draw repeats until the whole sprite has been plotted
    assign step_done = (phase == ph_wait) && dp_finished &&
                       ((step != st_draw_pixel) || last_pixel);

    always_comb begin
        instr_next = '0;
        case (step)
            st_read_x: begin
                instr_next.mem.addr = field_addr(job.id, `ANT_FIELD_X);
                instr_next.mem.opcode = `OPCODE_MEMREAD;
            end
            st_read_y: begin
                instr_next.mem.addr = field_addr(job.id, `ANT_FIELD_Y);
                instr_next.mem.opcode = `OPCODE_MEMREAD;
            end
            st_read_fitness: begin
                instr_next.mem.addr = field_addr(job.id, `ANT_FIELD_FITNESS);
                instr_next.mem.opcode = `OPCODE_MEMREAD;
            end
            st_draw_pixel: begin
                instr_next.draw.plot = 1'b1;
                instr_next.draw.colour = `COLOUR_ANT;
                // Sprite origin plus offset wraps at the screen edge
                instr_next.draw.y = regs.y + dy;
                instr_next.draw.x = regs.x + dx;
                instr_next.draw.opcode = `OPCODE_DRAW;
            end
            st_write_x: begin
                instr_next.mem.data = `RESULT_WIDTH'(regs.x);
                instr_next.mem.addr = field_addr(job.id, `ANT_FIELD_X);
                instr_next.mem.opcode = `OPCODE_MEMWRITE;
            end
            st_write_y: begin
                instr_next.mem.data = `RESULT_WIDTH'(regs.y);
                instr_next.mem.addr = field_addr(job.id, `ANT_FIELD_Y);
                instr_next.mem.opcode = `OPCODE_MEMWRITE;
            end
            st_write_fitness: begin
                instr_next.mem.data = `RESULT_WIDTH'(regs.fitness);
                instr_next.mem.addr = field_addr(job.id, `ANT_FIELD_FITNESS);
                instr_next.mem.opcode = `OPCODE_MEMWRITE;
            end
            default: begin
                instr_next = '0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            phase <= ph_idle;
            dp_start <= 1'b0;
            dx <= '0;
            dy <= '0;
        end else begin
            case (phase)
                ph_idle: begin
                    if (issue) begin
                        phase <= ph_start;
                        dp_start <= 1'b1;
                    end
                end
                ph_start: begin
                    phase <= ph_hold;
                end
                ph_hold: begin
                    phase <= ph_wait;
                    dp_start <= 1'b0;
                end
                default: begin
                    if (dp_finished) begin
                        phase <= ph_idle;
                        // dx runs fastest across the sprite
                        if (step == st_draw_pixel) begin
                            if (dx == `X_COORD_WIDTH'(`ANT_WIDTH - 1)) begin
                                dx <= '0;
                                if (last_pixel) begin
                                    dy <= '0;
                                end else begin
                                    dy <= dy + `Y_COORD_WIDTH'd1;
                                end
                            end else begin
                                dx <= dx + `X_COORD_WIDTH'd1;
                            end
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            dp_instruction <= instr_next;
        end
    end

    // Datapath samples the instruction at any point of the start pulse
    a_instr_stable: assert property (
        @(posedge clock) disable iff (!resetn)
        dp_start && $past(dp_start) |-> $stable(dp_instruction)
    ) else $error("dp_instruction changed while dp_start was high");

endmodule

/* hw/ant_state_regs.sv */
`include "ant_params.svh"

module ant_state_regs (
    input  logic                     clock,
    input  logic                     resetn,
    input  ant_pkg::ant_step_e       step,
    input  ant_pkg::ant_cmd_t        job,
    input  logic                     dp_finished,
    input  logic [`RESULT_WIDTH-1:0] dp_result,
    output ant_pkg::ant_regs_t       regs
);
    import ant_pkg::*;

    logic [`X_COORD_WIDTH-1:0] x_in;
    logic [`Y_COORD_WIDTH-1:0] y_in;
    logic [`X_COORD_WIDTH-1:0] x_next;
    logic [`Y_COORD_WIDTH-1:0] y_next;

    assign x_in = dp_result[`X_COORD_WIDTH-1:0];
    assign y_in = dp_result[`Y_COORD_WIDTH-1:0];

    always_comb begin
        if (job.op == op_draw) begin
            // Sprite is centred one pixel up and left of the ant
            x_next = x_in - `X_COORD_WIDTH'd1;
            y_next = y_in - `Y_COORD_WIDTH'd1;
        end else begin
            // Opposite flags cancel; edges wrap
            x_next = x_in - `X_COORD_WIDTH'(job.move.left) + `X_COORD_WIDTH'(job.move.right);
            y_next = y_in - `Y_COORD_WIDTH'(job.move.up) + `Y_COORD_WIDTH'(job.move.down);
        end
    end

    // Read results land on the same edge as dp_finished
    always_ff @(posedge clock) begin
        if (!resetn) begin
            regs <= '0;
        end else if (dp_finished) begin
            case (step)
                st_read_x: begin
                    regs.x <= x_next;
                end
                st_read_y: begin
                    regs.y <= y_next;
                end
                st_read_fitness: begin
                    regs.fitness <= dp_result[`FITNESS_WIDTH-1:0];
                end
                default: begin
                    regs <= regs;
                end
            endcase
        end
    end

endmodule

/* hw/ant_engine.sv */
`include "ant_params.svh"

module ant_engine (
    input  logic                     clock,
    input  logic                     resetn,
    input  logic                     start,
    input  ant_pkg::ant_cmd_t        cmd,
    output logic                     finished,
    output logic                     dp_start,
    output ant_pkg::ant_instr_u      dp_instruction,
    input  logic                     dp_finished,
    input  logic [`RESULT_WIDTH-1:0] dp_result
);
    import ant_pkg::*;

    ant_step_e step;
    ant_cmd_t  job;
    ant_regs_t regs;
    logic      step_done;

    // Host command and step order
    ant_cmd_decode i_decode (
        .clock     (clock),
        .resetn    (resetn),
        .start     (start),
        .cmd       (cmd),
        .step_done (step_done),
        .finished  (finished),
        .step      (step),
        .job       (job)
    );

    // Datapath handshake and instruction build
    ant_dp_sequencer i_sequencer (
        .clock          (clock),
        .resetn         (resetn),
        .step           (step),
        .job            (job),
        .regs           (regs),
        .dp_finished    (dp_finished),
        .dp_start       (dp_start),
        .dp_instruction (dp_instruction),
        .step_done      (step_done)
    );

    ant_state_regs i_state_regs (
        .clock       (clock),
        .resetn      (resetn),
        .step        (step),
        .job         (job),
        .dp_finished (dp_finished),
        .dp_result   (dp_result),
        .regs        (regs)
    );

endmodule

/* bench/ant_dp_model.sv */
`include "ant_params.svh"

module ant_dp_model (
    input  logic                     clock,
    input  logic                     dp_start,
    input  ant_pkg::ant_instr_u      dp_instruction,
    input  logic [2:0]               resp_delay,
    output logic                     dp_finished,
    output logic [`RESULT_WIDTH-1:0] dp_result
);
    timeunit 1ns;
    timeprecision 1ps;
    import ant_pkg::*;

    localparam int mem_words = 1 << `MEM_ADDR_WIDTH;

    logic [`RESULT_WIDTH-1:0] mem [mem_words];
    draw_instr_t              pixel_log [$];
    int                       bad_ops;
    ant_instr_u               instr;
    int                       wait_cycles;

    // Opcode sits in the same bits in both layouts
    task automatic apply_instruction(input ant_instr_u op);
        case (op.mem.opcode)
            `OPCODE_MEMREAD: begin
                dp_result <= mem[op.mem.addr];
            end
            `OPCODE_MEMWRITE: begin
                mem[op.mem.addr] = op.mem.data;
            end
            `OPCODE_DRAW: begin
                pixel_log.push_back(op.draw);
            end
            default: begin
                $display("datapath model: unknown opcode %0d", op.mem.opcode);
                bad_ops++;
            end
        endcase
    endtask

    initial begin
        dp_finished = 1'b0;
        dp_result = '0;
        bad_ops = 0;
        // Background words differ across the whole address range
        for (int a = 0; a < mem_words; a++) begin
            mem[a] = `RESULT_WIDTH'(a * 32'h0101 ^ 32'h9c35);
        end
        forever begin
            @(posedge clock);
            if (dp_start) begin
                instr = dp_instruction;
                // Sit out the rest of the start pulse
                while (dp_start) begin
                    @(posedge clock);
                end
                wait_cycles = int'(resp_delay);
                repeat (wait_cycles) begin
                    @(posedge clock);
                end
                apply_instruction(instr);
                dp_finished <= 1'b1;
                @(posedge clock);
                dp_finished <= 1'b0;
            end
        end
    end

endmodule

/* bench/ant_engine_tb.sv */
`include "ant_params.svh"

module ant_engine_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import ant_pkg::*;

    localparam int clock_period = 10;
    localparam int num_commands = 20;
    localparam int max_delay = 5;
    localparam int num_pixels = `ANT_WIDTH * `ANT_HEIGHT;
    localparam int mem_words = 1 << `MEM_ADDR_WIDTH;
    // A draw is the longest command with two reads and one step per pixel
    localparam int max_steps = 2 + num_pixels;
    // Issue, two start cycles, return pulse and slack, plus the response delay
    localparam int command_limit = max_steps * (5 + max_delay) + 10;
    localparam int watchdog_cycles = (num_commands + 1) * command_limit + 100;

    logic                     clock;
    logic                     resetn;
    logic                     start;
    ant_cmd_t                 cmd;
    logic                     finished;
    logic                     dp_start;
    ant_instr_u               dp_instruction;
    logic                     dp_finished;
    logic [`RESULT_WIDTH-1:0] dp_result;
    logic [2:0]               resp_delay;

    logic [31:0] stim_state;
    logic [31:0] delay_state;
    int          error_count;
    int          errors_at_start;
    int          pass_count;
    int          fail_count;
    int          high_cycles;
    bit          timed_out;
    bit          cmd_active;

    // Command under test as seen by the checker
    string                    cur_name;
    ant_cmd_t                 cur_cmd;
    ant_regs_t                cur_rec;
    int                       log_start;
    logic [`RESULT_WIDTH-1:0] mem_before [mem_words];
    event                     cmd_done;

    ant_engine i_dut (
        .clock          (clock),
        .resetn         (resetn),
        .start          (start),
        .cmd            (cmd),
        .finished       (finished),
        .dp_start       (dp_start),
        .dp_instruction (dp_instruction),
        .dp_finished    (dp_finished),
        .dp_result      (dp_result)
    );

    ant_dp_model i_model (
        .clock          (clock),
        .dp_start       (dp_start),
        .dp_instruction (dp_instruction),
        .resp_delay     (resp_delay),
        .dp_finished    (dp_finished),
        .dp_result      (dp_result)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [`MEM_ADDR_WIDTH-1:0] record_addr(
        input logic [`MEM_ADDR_WIDTH-1:0] id,
        input int                         offset
    );
        return `MEM_ADDR_WIDTH'(id * `ANT_REC_WORDS + offset);
    endfunction

    // Record after one move step with coordinates wrapping at the screen edge
    function automatic ant_regs_t expected_record(input ant_regs_t old, input ant_move_t move);
        ant_regs_t rec;
        rec = old;
        if (move.left) begin
            rec.x = rec.x - `X_COORD_WIDTH'd1;
        end
        if (move.right) begin
            rec.x = rec.x + `X_COORD_WIDTH'd1;
        end
        if (move.up) begin
            rec.y = rec.y - `Y_COORD_WIDTH'd1;
        end
        if (move.down) begin
            rec.y = rec.y + `Y_COORD_WIDTH'd1;
        end
        return rec;
    endfunction

    // Pixel k of the sprite whose origin is one up and left of the ant
    function automatic draw_instr_t expected_pixel(input ant_regs_t ant, input int k);
        draw_instr_t pix;
        pix = '0;
        pix.plot = 1'b1;
        pix.colour = `COLOUR_ANT;
        pix.x = ant.x - `X_COORD_WIDTH'd1 + `X_COORD_WIDTH'(k % `ANT_WIDTH);
        pix.y = ant.y - `Y_COORD_WIDTH'd1 + `Y_COORD_WIDTH'(k / `ANT_WIDTH);
        pix.opcode = `OPCODE_DRAW;
        return pix;
    endfunction

    task automatic report_test(input string name);
        if (error_count == errors_at_start) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, error_count - errors_at_start);
        end
    endtask

    task automatic run_command(input string name, input ant_cmd_t c, input ant_regs_t rec);
        int waited;
        errors_at_start = error_count;
        i_model.mem[record_addr(c.id, `ANT_FIELD_X)] = `RESULT_WIDTH'(rec.x);
        i_model.mem[record_addr(c.id, `ANT_FIELD_Y)] = `RESULT_WIDTH'(rec.y);
        i_model.mem[record_addr(c.id, `ANT_FIELD_FITNESS)] = `RESULT_WIDTH'(rec.fitness);
        for (int a = 0; a < mem_words; a++) begin
            mem_before[a] = i_model.mem[a];
        end
        log_start = i_model.pixel_log.size();
        cur_name = name;
        cur_cmd = c;
        cur_rec = rec;
        cmd_active = 1'b1;
        start <= 1'b1;
        cmd <= c;
        @(posedge clock);
        start <= 1'b0;
        @(posedge clock);
        assert (!finished) else begin
            $display("%s: finished did not fall after the start pulse", name);
            error_count++;
        end
        waited = 0;
        while (!finished && waited < command_limit) begin
            @(posedge clock);
            waited++;
        end
        assert (finished) else begin
            $display("%s: finished did not rise within %0d cycles", name, command_limit);
            error_count++;
            timed_out = 1'b1;
        end
        cmd_active = 1'b0;
        -> cmd_done;
        @(posedge clock);
    endtask

    task automatic check_command();
        logic [`RESULT_WIDTH-1:0] expected_mem [mem_words];
        ant_regs_t                want;
        draw_instr_t              want_pix;
        int                       got_pixels;
        for (int a = 0; a < mem_words; a++) begin
            expected_mem[a] = mem_before[a];
        end
        got_pixels = i_model.pixel_log.size() - log_start;
        if (cur_cmd.op == op_update) begin
            want = expected_record(cur_rec, cur_cmd.move);
            expected_mem[record_addr(cur_cmd.id, `ANT_FIELD_X)] = `RESULT_WIDTH'(want.x);
            expected_mem[record_addr(cur_cmd.id, `ANT_FIELD_Y)] = `RESULT_WIDTH'(want.y);
            expected_mem[record_addr(cur_cmd.id, `ANT_FIELD_FITNESS)] =
                `RESULT_WIDTH'(want.fitness);
            assert (got_pixels == 0) else begin
                $display("MISMATCH %s pixel count: expected 0, actual %0d", cur_name, got_pixels);
                error_count++;
            end
        end else begin
            assert (got_pixels == num_pixels) else begin
                $display("MISMATCH %s pixel count: expected %0d, actual %0d",
                         cur_name, num_pixels, got_pixels);
                error_count++;
            end
            for (int k = 0; k < num_pixels && k < got_pixels; k++) begin
                want_pix = expected_pixel(cur_rec, k);
                assert (i_model.pixel_log[log_start + k] == want_pix) else begin
                    $display("MISMATCH %s pixel %0d: expected %h, actual %h",
                             cur_name, k, want_pix, i_model.pixel_log[log_start + k]);
                    error_count++;
                end
            end
        end
        // Every record word so that stray writes to other ants show up too
        for (int a = 0; a < mem_words; a++) begin
            assert (i_model.mem[a] == expected_mem[a]) else begin
                $display("MISMATCH %s word %0d: expected %h, actual %h",
                         cur_name, a, expected_mem[a], i_model.mem[a]);
                error_count++;
            end
        end
        report_test(cur_name);
    endtask

    always @(cmd_done) begin
        check_command();
    end

    initial begin
        clock = 1'b0;
        forever begin
            #(clock_period / 2) clock = ~clock;
        end
    end

    // New response delay every cycle for the model to take when a step needs one
    always @(posedge clock) begin
        delay_state = lcg_next(delay_state);
        resp_delay <= 3'((delay_state >> 16) % (max_delay + 1));
    end

    // Datapath port protocol
    always @(posedge clock) begin
        if (resetn) begin
            assert (!(finished && dp_start)) else begin
                $display("dp_start was raised while the engine was idle");
                error_count++;
            end
            assert (finished || cmd_active) else begin
                $display("finished was low while no command was running");
                error_count++;
            end
            if (dp_start) begin
                high_cycles++;
            end else if (high_cycles != 0) begin
                assert (high_cycles == 2) else begin
                    $display("MISMATCH %s dp_start cycles: expected 2, actual %0d",
                             cur_name, high_cycles);
                    error_count++;
                end
                high_cycles = 0;
            end
        end
    end

    initial begin
        #(watchdog_cycles * clock_period);
        $display("watchdog: run did not end within %0d cycles", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        ant_cmd_t    c;
        ant_regs_t   rec;
        logic [31:0] rnd;
        resetn = 1'b0;
        start = 1'b0;
        cmd = '0;
        resp_delay = '0;
        stim_state = 32'd69724;
        delay_state = 32'd69724;
        error_count = 0;
        pass_count = 0;
        fail_count = 0;
        high_cycles = 0;
        timed_out = 1'b0;
        cmd_active = 1'b0;
        log_start = 0;
        cur_name = "reset";
        repeat (2) @(posedge clock);
        resetn <= 1'b1;
        @(posedge clock);

        errors_at_start = error_count;
        assert (finished == 1'b1) else begin
            $display("MISMATCH reset finished: expected 1, actual %b", finished);
            error_count++;
        end
        assert (dp_start == 1'b0) else begin
            $display("MISMATCH reset dp_start: expected 0, actual %b", dp_start);
            error_count++;
        end
        report_test("reset");

        for (int i = 0; i < num_commands && !timed_out; i++) begin
            stim_state = lcg_next(stim_state);
            rnd = stim_state;
            c.op = (i % 2 == 0) ? op_draw : op_update;
            c.id = `MEM_ADDR_WIDTH'(rnd[29:24]);
            c.move = ant_move_t'(rnd[3:0]);
            stim_state = lcg_next(stim_state);
            rnd = stim_state;
            rec.x = rnd[23:16];
            rec.y = rnd[30:24];
            rec.fitness = rnd[15:8];
            if (i % 4 < 2) begin
                // Put the ant on a screen edge and move it outward
                rec.x = {`X_COORD_WIDTH{rnd[0]}};
                rec.y = {`Y_COORD_WIDTH{rnd[1]}};
                c.move.left = !rnd[0];
                c.move.right = rnd[0];
                c.move.up = !rnd[1];
                c.move.down = rnd[1];
            end
            run_command($sformatf("%s_%0d", (c.op == op_draw) ? "draw" : "update", i), c, rec);
        end

        assert (i_model.bad_ops == 0) else begin
            $display("datapath model received %0d instructions with an unknown opcode",
                     i_model.bad_ops);
            error_count++;
        end
        $display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* ant_engine.f */
+incdir+hw
hw/ant_pkg.sv
hw/ant_cmd_decode.sv
hw/ant_dp_sequencer.sv
hw/ant_state_regs.sv
hw/ant_engine.sv
bench/ant_dp_model.sv
bench/ant_engine_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ant engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module ant_engine_tb \
    -f ant_engine.f \
    -o ant_engine_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/ant_engine_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
exit 1
